/* verilog/xbar_defs.svh */
`ifndef XBAR_DEFS_SVH
`define XBAR_DEFS_SVH

// ----------------------------------------------------------------------
// configuration image size
// ----------------------------------------------------------------------

// 16 words of 32 bits
`define XBAR_WORDS 16

// serial bits per programming run
`define XBAR_BITS 512

// ----------------------------------------------------------------------
// register offsets within the bus page
// ----------------------------------------------------------------------

`define XBAR_CMD_OFS    8'h20   // command, nonzero starts a run
`define XBAR_STATUS_OFS 8'h21   // busy, overrun, run count
`define XBAR_ID_OFS     8'h09   // fixed id, read only

// id value, reads a bit like "XbaR"
`define XBAR_ID_VALUE 16'h7ba2

`endif

/* verilog/xbar_pkg.sv */
package xbar_pkg;

  // ----------------------------------------------------------------------
  // shift sequencer states
  // ----------------------------------------------------------------------
  typedef enum logic [2:0] {
    idle         = 3'd0,  // waiting for prog_req
    load         = 3'd1,  // sin settles, xbar_clock low
    pulse_clk    = 3'd2,  // xbar_clock high, shift on exit
    load_shift   = 3'd3,  // fetch next 32-bit word
    pulse_pclk   = 3'd4,  // pclk low for one cycle
    wait_release = 3'd5   // prog_ack high until req drops
  } seq_state_t;

  // ----------------------------------------------------------------------
  // decoded bus operation for the current cycle
  // ----------------------------------------------------------------------
  typedef enum logic [2:0] {
    none      = 3'd0,  // no access to this page
    wr_config = 3'd1,  // write to one of the config words
    wr_cmd    = 3'd2,  // write to the command register
    rd_id     = 3'd3,  // read of the id register
    rd_status = 3'd4,  // read of the status register
    rd_other  = 3'd5   // read of an unmapped offset
  } bus_op_t;

endpackage

/* verilog/xbar_bus_decode.sv */
`include "xbar_defs.svh"

module xbar_bus_decode #(
  parameter logic [7:0] POSITION = 8'h00  // upper address byte we answer on
) (
  input  logic              sclk,
  input  logic              reset,
  input  logic              cmd_bus_enable,
  input  logic              cmd_bus_wr,
  input  logic              re,
  input  logic [15:0]       cmd_bus_addr,
  input  logic [31:0]       cmd_bus_data,
  output logic [15:0]       data_out,
  input  logic [3:0]        cfg_index,   // word the sequencer is loading
  output logic [31:0]       cfg_word,
  output logic              prog_req,
  input  logic              prog_ack,
  output xbar_pkg::bus_op_t bus_op,
  input  logic [15:0]       status_word
);

  logic        page_hit;
  logic [7:0]  offset;
  logic [31:0] cfg_mem [`XBAR_WORDS];  // 16 x 32 = 512 config bits
  logic [31:0] command;

  assign page_hit = cmd_bus_enable && (cmd_bus_addr[15:8] == POSITION);
  assign offset   = cmd_bus_addr[7:0];

  // ----------------------------------------------------------------------
  // page and offset decode, writes win over reads
  // ----------------------------------------------------------------------
  always_comb begin
    bus_op = xbar_pkg::none;
    if (page_hit && cmd_bus_wr) begin
      if (offset == `XBAR_CMD_OFS)
        bus_op = xbar_pkg::wr_cmd;
      else if (offset[7:4] == 4'h0)  // offsets 0x00..0x0f hold the words
        bus_op = xbar_pkg::wr_config;
    end else if (page_hit && re) begin
      case (offset)
        `XBAR_ID_OFS:     bus_op = xbar_pkg::rd_id;
        `XBAR_STATUS_OFS: bus_op = xbar_pkg::rd_status;
        default:          bus_op = xbar_pkg::rd_other;
      endcase
    end
  end

  // config word file, written from the bus, read by the sequencer
  always_ff @(posedge sclk) begin
    if (bus_op == xbar_pkg::wr_config)
      cfg_mem[cmd_bus_addr[3:0]] <= cmd_bus_data;
  end

  assign cfg_word = cfg_mem[cfg_index];  // combinational read port

  // ----------------------------------------------------------------------
  // command register and request side of the handshake
  // ----------------------------------------------------------------------
  always_ff @(posedge sclk) begin
    if (reset) begin
      command  <= '0;
      prog_req <= 1'b0;
    end else begin
      if (prog_req && prog_ack) begin
        command  <= '0;    // run done, clear command
        prog_req <= 1'b0;  // and release the request
      end else begin
        if (bus_op == xbar_pkg::wr_cmd && !prog_req)
          command <= cmd_bus_data;  // dropped while a run is pending
        if (command != '0 && !prog_ack)
          prog_req <= 1'b1;  // no new request until ack has fallen
      end
    end
  end

  // registered read mux, one cycle latency
  always_ff @(posedge sclk) begin
    if (reset)
      data_out <= '0;
    else begin
      case (bus_op)
        xbar_pkg::rd_id:     data_out <= `XBAR_ID_VALUE;
        xbar_pkg::rd_status: data_out <= status_word;
        default:             data_out <= '0;  // unmapped, other page, no read
      endcase
    end
  end

  // request is only withdrawn after the sequencer acknowledged
  a_req_held: assert property (@(posedge sclk) disable iff (reset)
    $fell(prog_req) |-> $past(prog_ack))
    else $error("prog_req fell without prog_ack");

endmodule

/* verilog/xbar_shift_sequencer.sv */
`include "xbar_defs.svh"

module xbar_shift_sequencer (
  input  logic        sclk,
  input  logic        reset,
  input  logic        prog_req,
  output logic        prog_ack,
  output logic [3:0]  cfg_index,
  input  logic [31:0] cfg_word,
  output logic        busy,
  output logic        xbar_clock,  // bit clock to the matrix
  output logic        pclk,        // active low, one pulse sets the switches
  output logic        sin          // serial data, msb first
);

  xbar_pkg::seq_state_t state;
  xbar_pkg::seq_state_t state_nxt;
  logic [8:0]           bit_cnt;    // bits already shifted out
  logic [31:0]          shift_reg;
  logic                 last_bit;
  logic                 word_end;

  assign last_bit = (bit_cnt == 9'(`XBAR_BITS - 1));
  assign word_end = (bit_cnt[4:0] == 5'h1f);  // 32nd bit of a word

  // ----------------------------------------------------------------------
  // next state
  // ----------------------------------------------------------------------
  always_comb begin
    state_nxt = state;
    case (state)
      xbar_pkg::idle: begin
        if (prog_req)
          state_nxt = xbar_pkg::load;
      end
      xbar_pkg::load:
        state_nxt = xbar_pkg::pulse_clk;
      xbar_pkg::pulse_clk: begin
        if (last_bit)
          state_nxt = xbar_pkg::pulse_pclk;
        else if (word_end)
          state_nxt = xbar_pkg::load_shift;
        else
          state_nxt = xbar_pkg::load;
      end
      xbar_pkg::load_shift:
        state_nxt = xbar_pkg::load;
      xbar_pkg::pulse_pclk:
        state_nxt = xbar_pkg::wait_release;
      xbar_pkg::wait_release: begin
        if (!prog_req)
          state_nxt = xbar_pkg::idle;  // four-phase close
      end
      default:
        state_nxt = xbar_pkg::idle;
    endcase
  end

  // ----------------------------------------------------------------------
  // state, bit counter and shift register
  // ----------------------------------------------------------------------
  always_ff @(posedge sclk) begin
    if (reset) begin
      state     <= xbar_pkg::idle;
      bit_cnt   <= '0;
      shift_reg <= '0;  // keeps sin low out of reset
    end else begin
      state <= state_nxt;
      case (state)
        xbar_pkg::idle: begin
          bit_cnt <= '0;
          if (prog_req)
            shift_reg <= cfg_word;  // word 0
        end
        xbar_pkg::pulse_clk: begin
          shift_reg <= {shift_reg[30:0], 1'b0};  // next bit up top
          if (!last_bit)
            bit_cnt <= bit_cnt + 9'd1;
        end
        xbar_pkg::load_shift:
          shift_reg <= cfg_word;  // index already advanced by bit_cnt
        xbar_pkg::pulse_pclk:
          bit_cnt <= '0;
        default: ;
      endcase
    end
  end

  assign cfg_index  = bit_cnt[8:5];  // 32 bits per word
  assign sin        = shift_reg[31];
  assign xbar_clock = (state == xbar_pkg::pulse_clk);
  assign pclk       = (state != xbar_pkg::pulse_pclk);
  assign prog_ack   = (state == xbar_pkg::wait_release);
  assign busy       = prog_req || (state != xbar_pkg::idle);

  // pclk low only right after the final xbar_clock, never with it
  a_pclk_after_clk: assert property (@(posedge sclk) disable iff (reset)
    !pclk |-> (!xbar_clock && $past(xbar_clock)))
    else $error("pclk pulse not right after last xbar_clock");

  // counter stops at the last bit and the run ends there
  a_cnt_stop: assert property (@(posedge sclk) disable iff (reset)
    (state == xbar_pkg::pulse_clk && last_bit) |=>
      (state == xbar_pkg::pulse_pclk && bit_cnt == 9'(`XBAR_BITS - 1)))
    else $error("bit counter ran past the last bit");

endmodule

/* verilog/xbar_program_status.sv */
module xbar_program_status (
  input  logic              sclk,
  input  logic              reset,
  input  xbar_pkg::bus_op_t bus_op,
  input  logic              prog_req,
  input  logic              prog_ack,
  input  logic              busy,
  output logic [15:0]       status_word
);

  logic        ack_q;    // prog_ack one cycle late
  logic        ack_rise;
  logic [13:0] run_cnt;  // finished runs, saturates
  logic        overrun;  // sticky until reset

  assign ack_rise = prog_ack && !ack_q;

  // ----------------------------------------------------------------------
  // run count and overrun flag
  // ----------------------------------------------------------------------
  always_ff @(posedge sclk) begin
    if (reset) begin
      ack_q   <= 1'b0;
      run_cnt <= '0;
      overrun <= 1'b0;
    end else begin
      ack_q <= prog_ack;

      // one ack edge per finished run
      if (ack_rise && run_cnt != '1)
        run_cnt <= run_cnt + 14'd1;

      // command written while a run is still pending
      if (bus_op == xbar_pkg::wr_cmd && prog_req)
        overrun <= 1'b1;
    end
  end

  // bit 15 busy, bit 14 overrun, 13:0 run count
  assign status_word = {busy, overrun, run_cnt};

endmodule

/* verilog/xbar_config_top.sv */
module xbar_config_top #(
  parameter logic [7:0] POSITION = 8'h00  // bus page of this controller
) (
  input  logic        sclk,
  input  logic        reset,
  input  logic        cmd_bus_enable,
  input  logic        cmd_bus_wr,
  input  logic        re,
  input  logic [15:0] cmd_bus_addr,
  input  logic [31:0] cmd_bus_data,
  output logic [15:0] data_out,
  output logic        busy,
  output logic        xbar_clock,  // matrix side
  output logic        pclk,
  output logic        sin
);

  logic [3:0]        cfg_index;
  logic [31:0]       cfg_word;
  logic              prog_req;    // decode -> sequencer
  logic              prog_ack;    // sequencer -> decode
  xbar_pkg::bus_op_t bus_op;
  logic [15:0]       status_word;

  // ----------------------------------------------------------------------
  // bus side, word file and handshake request
  // ----------------------------------------------------------------------
  xbar_bus_decode #(
    .POSITION (POSITION)
  ) i_decode (
    .sclk           (sclk),
    .reset          (reset),
    .cmd_bus_enable (cmd_bus_enable),
    .cmd_bus_wr     (cmd_bus_wr),
    .re             (re),
    .cmd_bus_addr   (cmd_bus_addr),
    .cmd_bus_data   (cmd_bus_data),
    .data_out       (data_out),
    .cfg_index      (cfg_index),
    .cfg_word       (cfg_word),
    .prog_req       (prog_req),
    .prog_ack       (prog_ack),
    .bus_op         (bus_op),
    .status_word    (status_word)
  );

  // serial stream to the switch matrix
  xbar_shift_sequencer i_sequencer (
    .sclk       (sclk),
    .reset      (reset),
    .prog_req   (prog_req),
    .prog_ack   (prog_ack),
    .cfg_index  (cfg_index),
    .cfg_word   (cfg_word),
    .busy       (busy),
    .xbar_clock (xbar_clock),
    .pclk       (pclk),
    .sin        (sin)
  );

  // status word for readback
  xbar_program_status i_status (
    .sclk        (sclk),
    .reset       (reset),
    .bus_op      (bus_op),
    .prog_req    (prog_req),
    .prog_ack    (prog_ack),
    .busy        (busy),
    .status_word (status_word)
  );

endmodule

/* verification/tb_xbar_config.sv */
`include "xbar_defs.svh"

module tb_xbar_config;

  localparam logic [7:0] PAGE = 8'h00;  // bus page of the DUT

  logic        sclk = 1'b0;
  logic        reset = 1'b1;
  logic        cmd_bus_enable = 1'b0;
  logic        cmd_bus_wr = 1'b0;
  logic        re = 1'b0;
  logic [15:0] cmd_bus_addr = '0;
  logic [31:0] cmd_bus_data = '0;
  logic [15:0] data_out;
  logic        busy;
  logic        xbar_clock;
  logic        pclk;
  logic        sin;

  logic [1:0]  op_q [$];   // 0 write, 1 read, 2 program
  logic [31:0] addr_q [$];
  logic [31:0] data_q [$];
  int          dup_q [$];  // extra command writes while busy

  int              mismatches = 0;
  int              failures = 0;
  int              cycle_cnt = 0;
  int              cycle_limit = 0;  // set once the trace is loaded
  logic            clk_q = 1'b0;
  logic [511:0]    sin_capture = '0;
  int              clk_pulses = 0;
  int              pclk_lows = 0;
  int              clk_at_pclk = 0;  // pulse count when pclk went low
  int              busy_gaps = 0;
  logic [31:0]     model [`XBAR_WORDS];  // expected word file
  int              runs_done = 0;
  logic            exp_overrun = 1'b0;

  xbar_config_top #(.POSITION (PAGE)) i_dut (
    .sclk           (sclk),
    .reset          (reset),
    .cmd_bus_enable (cmd_bus_enable),
    .cmd_bus_wr     (cmd_bus_wr),
    .re             (re),
    .cmd_bus_addr   (cmd_bus_addr),
    .cmd_bus_data   (cmd_bus_data),
    .data_out       (data_out),
    .busy           (busy),
    .xbar_clock     (xbar_clock),
    .pclk           (pclk),
    .sin            (sin)
  );

  always #5 sclk = ~sclk;

  // hard stop at a limit taken from the trace length
  always @(posedge sclk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      $display("timeout: no finish after %0d cycles", cycle_cnt);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // ----------------------------------------------------------------------
  // serial stream monitor sampling the values of the cycle just ended
  // ----------------------------------------------------------------------
  always @(posedge sclk) begin
    clk_q <= xbar_clock;
    if (xbar_clock && !clk_q) begin
      sin_capture <= {sin_capture[`XBAR_BITS-2:0], sin};  // word 0 msb ends on top
      clk_pulses  <= clk_pulses + 1;
    end
    if (!pclk) begin
      pclk_lows   <= pclk_lows + 1;
      clk_at_pclk <= clk_pulses;
    end
    if ((xbar_clock || !pclk) && !busy)
      busy_gaps <= busy_gaps + 1;  // matrix activity outside busy
  end

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      mismatches++;
      $display("Mismatch %s: got 0x%08h, expected 0x%08h", name, actual, expected);
    end
  endtask

  task automatic report_failure(input string what);
    failures++;
    $display("failure: %s", what);
  endtask

  // one bus cycle with inputs changing 1 unit after the edge
  task automatic bus_write(input logic [15:0] addr, input logic [31:0] data);
    @(posedge sclk);
    #1;
    cmd_bus_enable = 1'b1;
    cmd_bus_wr     = 1'b1;
    cmd_bus_addr   = addr;
    cmd_bus_data   = data;
    @(posedge sclk);
    #1;
    cmd_bus_enable = 1'b0;
    cmd_bus_wr     = 1'b0;
  endtask

  task automatic bus_read(input logic [15:0] addr, output logic [15:0] value);
    @(posedge sclk);
    #1;
    cmd_bus_enable = 1'b1;
    re             = 1'b1;
    cmd_bus_addr   = addr;
    @(posedge sclk);
    #1;
    value          = data_out;  // registered so valid one cycle later
    cmd_bus_enable = 1'b0;
    re             = 1'b0;
  endtask

  // ----------------------------------------------------------------------
  // command write, wait for the run, then check stream and status
  // ----------------------------------------------------------------------
  task automatic run_program(input logic [15:0] addr, input logic [31:0] cmd,
                             input int dup);
    int          clk_start;
    int          pclk_start;
    int          gap_start;
    logic [15:0] status;
    clk_start  = clk_pulses;
    pclk_start = pclk_lows;
    gap_start  = busy_gaps;
    bus_write(addr, cmd);
    while (!busy) begin
      @(posedge sclk);
      #1;
    end
    bus_read({PAGE, `XBAR_STATUS_OFS}, status);  // busy bit set mid-run
    check_value("status_word busy", 32'(status),
                32'({1'b1, exp_overrun, 14'(runs_done)}));
    for (int d = 0; d < dup; d++) begin
      repeat (4) @(posedge sclk);
      bus_write(addr, cmd);  // dropped since the run is still pending
      exp_overrun = 1'b1;
    end
    while (busy) begin
      @(posedge sclk);
      #1;
    end
    if (clk_pulses - clk_start != `XBAR_BITS)
      report_failure($sformatf("run gave %0d xbar_clock pulses instead of %0d",
                               clk_pulses - clk_start, `XBAR_BITS));
    if (pclk_lows - pclk_start != 1)
      report_failure($sformatf("run gave %0d pclk low cycles instead of one",
                               pclk_lows - pclk_start));
    else if (clk_at_pclk != clk_start + `XBAR_BITS)
      report_failure("pclk pulse did not follow the last xbar_clock");
    if (busy_gaps != gap_start)
      report_failure("busy was low while the matrix was being clocked");
    for (int w = 0; w < `XBAR_WORDS; w++)
      check_value($sformatf("sin word %0d", w),
                  sin_capture[`XBAR_BITS-1-32*w -: 32], model[w]);
    runs_done++;
    repeat (6) @(posedge sclk);
    #1;
    if (busy || clk_pulses != clk_start + `XBAR_BITS)
      report_failure("an extra run started after the program run");
    bus_read({PAGE, `XBAR_STATUS_OFS}, status);
    check_value("status_word", 32'(status), 32'({1'b0, exp_overrun, 14'(runs_done)}));
  endtask

  initial begin
    int          fd;
    int          code;
    int          dup;
    int          prog_lines;
    string       line_str;
    logic [55:0] op_text;
    logic [31:0] addr;
    logic [31:0] data;
    logic [15:0] value;
    void'($urandom(32'hf3160ef2));  // gaps only
    prog_lines = 0;
    fd = $fopen("verification/xbar_trace.txt", "r");
    if (fd == 0)
      report_failure("could not open verification/xbar_trace.txt");
    else begin
      while ($fgets(line_str, fd) > 0) begin
        code = $sscanf(line_str, "%s %h %h %d", op_text, addr, data, dup);
        if (line_str[0] == "#" || code <= 0)
          continue;  // comment or blank
        if (code != 4)
          report_failure($sformatf("malformed trace line %s", line_str));
        else if (op_text == 56'("write") || op_text == 56'("read") ||
                 op_text == 56'("program")) begin
          op_q.push_back(op_text == 56'("write") ? 2'd0 :
                         op_text == 56'("read")  ? 2'd1 : 2'd2);
          addr_q.push_back(addr);
          data_q.push_back(data);
          dup_q.push_back(dup);
          if (op_text == 56'("program"))
            prog_lines++;
        end else
          report_failure($sformatf("unknown trace operation in %s", line_str));
      end
      $fclose(fd);
    end
    if (op_q.size() == 0)
      report_failure("trace file held no usable lines");
    cycle_limit = prog_lines * 1200 + op_q.size() * 20;

    repeat (10) @(posedge sclk);
    #1;
    reset = 1'b0;
    check_value("busy", 32'(busy), 32'h0);
    check_value("pclk", 32'(pclk), 32'h1);
    check_value("xbar_clock", 32'(xbar_clock), 32'h0);
    check_value("sin", 32'(sin), 32'h0);
    check_value("data_out", 32'(data_out), 32'h0);

    for (int i = 0; i < op_q.size(); i++) begin
      repeat ($urandom % 4) @(posedge sclk);  // idle gap
      case (op_q[i])
        2'd0: begin
          bus_write(addr_q[i][15:0], data_q[i]);
          if (addr_q[i][15:8] == PAGE && addr_q[i][7:4] == 4'h0)
            model[addr_q[i][3:0]] = data_q[i];  // only config words land
        end
        2'd1: begin
          bus_read(addr_q[i][15:0], value);
          check_value($sformatf("data_out @%04h", addr_q[i][15:0]), 32'(value), data_q[i]);
        end
        default: run_program(addr_q[i][15:0], data_q[i], dup_q[i]);
      endcase
    end

    $display("checks done: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

/* verification/xbar_trace.txt */
# columns: op (write, read, program), address (hex), data or expected value (hex), dup
# dup is the number of extra command writes a program line issues while busy
read    0021 00000000 0
read    0009 00007ba2 0
read    0005 00000000 0
read    0109 00000000 0
write   0000 a5a5f00f 0
write   0001 01234567 0
write   0002 89abcdef 0
write   0003 ffffffff 0
write   0004 00000000 0
write   0005 80000001 0
write   0006 deadbeef 0
write   0007 13579bdf 0
write   0008 2468ace0 0
write   0009 0f0f0f0f 0
write   000a f0f0f0f0 0
write   000b 55aa55aa 0
write   000c c3c33c3c 0
write   000d 7fffffff 0
write   000e fffffffe 0
write   000f 31415926 0
write   0103 11111111 0
program 0020 00000001 0
read    0021 00000001 0
write   0002 cafef00d 0
write   000f 0badc0de 0
program 0020 00000003 1
read    0021 00004002 0

/* project.f */
+incdir+verilog
verilog/xbar_pkg.sv
verilog/xbar_bus_decode.sv
verilog/xbar_shift_sequencer.sv
verilog/xbar_program_status.sv
verilog/xbar_config_top.sv
verification/tb_xbar_config.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module tb_xbar_config \
  -o sim_xbar_config > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "verilator build failed, see build.log"
  exit 1
fi

./obj_dir/sim_xbar_config > sim.log 2>&1
if [ $? -ne 0 ]; then
  echo "simulation exited with an error, see sim.log"
  exit 1
fi

if grep -qx "ALL CHECKS PASSED" sim.log; then
  echo "result: pass"
  exit 0
else
  echo "result: fail, see sim.log"
  exit 1
fi
